// File: Bender.yml
package:
  name: prefetch_buffer

dependencies: {}

sources:
  - common/prefetch_pkg.sv
  - prefetch/fetch_fifo.sv
  - prefetch/prefetch_controller.sv
  - src/obi_instr_adapter.sv
  - src/prefetch_buffer.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/instr_mem_model.sv
      - tests/tb_prefetch_buffer.sv

// File: common/prefetch_pkg.sv
// Prefetch shared types and helpers: addresses, instruction words, tagged entries, count widths
`default_nettype none

package prefetch_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  // Byte address on the instruction bus
  typedef logic [31:0] addr_t;

  // Raw instruction word as returned by memory
  typedef logic [31:0] instr_t;

  // Word tagged with the address it came from
  typedef struct packed {
    addr_t  addr;
    instr_t rdata;
  } fetch_entry_t;

  // Request offered to the bus adapter
  // Room left for more attributes later
  typedef struct packed {
    addr_t addr;
  } bus_req_t;

  ////////////////////
  // Helpers
  ////////////////////

  // Bits needed for a count from 0 up to depth inclusive
  function automatic int unsigned cnt_width(input int unsigned depth);
    if (depth < 1) begin
      return 1;
    end
    return $clog2(depth + 1);
  endfunction

  // Drop the byte offset, fetches are always whole words
  function automatic addr_t word_align(input addr_t addr);
    return {addr[31:2], 2'b00};
  endfunction

endpackage

`default_nettype wire

// File: filelist.f
common/prefetch_pkg.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_controller.sv
src/obi_instr_adapter.sv
src/prefetch_buffer.sv
tests/tb_clk_gen.sv
tests/instr_mem_model.sv
tests/tb_prefetch_buffer.sv

// File: prefetch/fetch_fifo.sv
// Fetch FIFO: circular buffer of generic entries with fill count and single-cycle flush
`default_nettype none

module fetch_fifo #(
  parameter int unsigned depth   = 4,
  parameter type         entry_t = logic [31:0]
) (
  input  wire logic                                       clk,
  input  wire logic                                       rst_n,
  input  wire logic                                       flush_i,
  input  wire logic                                       push_i,
  input  wire entry_t                                     wdata_i,
  input  wire logic                                       pop_i,
  output entry_t                                          rdata_o,
  output logic [prefetch_pkg::cnt_width(depth)-1:0]       cnt_o,
  output logic                                            empty_o
);

  localparam int unsigned cnt_w = prefetch_pkg::cnt_width(depth);
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [ptr_w-1:0] ptr_t;

  // Storage
  entry_t           mem_q [depth];
  ptr_t             wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;

  // Pointer step with wrap, depth need not be a power of two
  function automatic ptr_t ptr_next(input ptr_t ptr);
    if (ptr == ptr_t'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rdata_o = mem_q[rd_ptr_q];
  assign cnt_o   = cnt_q;
  assign empty_o = (cnt_q == '0);

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Drop everything
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Push with pop keeps the count
      case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////
  // Data
  ////////////////////

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// File: prefetch/prefetch_controller.sv
// Prefetch controller: issues word fetches, tracks outstanding and stale responses, steers the FIFO
`default_nettype none

module prefetch_controller #(
  parameter int unsigned fifo_depth = 4,
  parameter int unsigned legacy_obi = 0
) (
  input  wire logic                                            clk,
  input  wire logic                                            rst_n,
  // Fetch stage
  input  wire logic                                            req_i,
  input  wire logic                                            branch_i,
  input  wire prefetch_pkg::addr_t                             branch_addr_i,
  output logic                                                 busy_o,
  // Transaction request to the adapter
  output logic                                                 trans_valid_o,
  input  wire logic                                            trans_ready_i,
  output prefetch_pkg::bus_req_t                               trans_req_o,
  // Response strobe, always accepted
  input  wire logic                                            resp_valid_i,
  // Fetch handshake
  input  wire logic                                            fetch_ready_i,
  output logic                                                 fetch_valid_o,
  // FIFO control
  output logic                                                 fifo_push_o,
  output logic                                                 fifo_pop_o,
  output logic                                                 fifo_flush_o,
  input  wire logic [prefetch_pkg::cnt_width(fifo_depth)-1:0]  fifo_cnt_i,
  input  wire logic                                            fifo_empty_i
);

  localparam int unsigned cnt_w = prefetch_pkg::cnt_width(fifo_depth);

  typedef enum logic {
    st_idle,
    st_branch_wait
  } state_t;

  state_t               state_q, state_d;
  logic [cnt_w-1:0]     cnt_q, cnt_d;
  logic [cnt_w-1:0]     flush_cnt_q, flush_cnt_d;
  prefetch_pkg::addr_t  trans_addr_q, trans_addr;
  prefetch_pkg::addr_t  trans_addr_incr;
  prefetch_pkg::addr_t  branch_target;
  logic [cnt_w:0]       fill_sum;
  logic                 has_room;
  logic                 accept;
  logic                 drop_resp;

  ////////////////////
  // Request gating
  ////////////////////

  // Words in the FIFO plus words still on the way, one bit wider so it cannot wrap
  assign fill_sum = fifo_cnt_i + cnt_q;
  assign has_room = fill_sum < fifo_depth;

  generate
    if (legacy_obi == 0) begin : g_obi
      // Pipelined requests, no path from rvalid to req
      assign trans_valid_o = req_i && has_room;
    end else begin : g_legacy
      // Next request only alongside the response of the previous one
      assign trans_valid_o = (cnt_q == '0) ? (req_i && has_room)
                                           : (req_i && has_room && resp_valid_i);
    end
  endgenerate

  assign accept = trans_valid_o && trans_ready_i;

  // Something in flight or on offer
  assign busy_o = (cnt_q != '0) || trans_valid_o;

  ////////////////////
  // Address FSM
  ////////////////////

  assign branch_target   = prefetch_pkg::word_align(branch_addr_i);
  assign trans_addr_incr = prefetch_pkg::word_align(trans_addr_q) + 32'd4;

  always_comb begin
    state_d    = state_q;
    trans_addr = trans_addr_q;
    case (state_q)
      st_idle: begin
        // New target wins over sequential prefetch
        trans_addr = branch_i ? branch_target : trans_addr_incr;
        if (branch_i && !accept) begin
          state_d = st_branch_wait;
        end
      end
      st_branch_wait: begin
        // Replay the target until granted, a newer branch replaces it
        trans_addr = branch_i ? branch_target : trans_addr_q;
        if (accept) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  assign trans_req_o = '{addr: trans_addr};

  ////////////////////
  // Fetch side and FIFO
  ////////////////////

  // Stale responses are discarded while the flush count runs down
  assign drop_resp = branch_i || (flush_cnt_q != '0);

  // Response goes straight out when the FIFO is empty (bypass)
  assign fetch_valid_o = (!fifo_empty_i || resp_valid_i) && !drop_resp;

  // Store unless the word bypasses to a ready consumer
  assign fifo_push_o  = resp_valid_i && !(fifo_empty_i && fetch_ready_i) && !drop_resp;
  assign fifo_pop_o   = !fifo_empty_i && fetch_ready_i;
  // Buffered words are stale after a branch
  assign fifo_flush_o = branch_i;

  ////////////////////
  // Counters
  ////////////////////

  // Outstanding transactions, up on grant and down on response
  always_comb begin
    cnt_d = cnt_q;
    case ({accept, resp_valid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // Responses still to throw away after a branch
  always_comb begin
    flush_cnt_d = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_d = cnt_q;
      // One of them is already arriving now
      if (resp_valid_i && (cnt_q != '0)) begin
        flush_cnt_d = cnt_q - 1'b1;
      end
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_d = flush_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= st_idle;
      cnt_q        <= '0;
      flush_cnt_q  <= '0;
      trans_addr_q <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      flush_cnt_q <= flush_cnt_d;
      // Hold the target on a branch, advance on every grant
      if (branch_i || accept) begin
        trans_addr_q <= trans_addr;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/obi_instr_adapter.sv
// Instruction bus adapter: forwards requests, tags in-order responses with their request address
`default_nettype none

module obi_instr_adapter #(
  parameter int unsigned depth = 4
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  // Controller side
  input  wire logic                         trans_valid_i,
  output logic                              trans_ready_o,
  input  wire prefetch_pkg::bus_req_t       trans_req_i,
  // Bus side
  output logic                              instr_req_o,
  input  wire logic                         instr_gnt_i,
  output prefetch_pkg::addr_t               instr_addr_o,
  input  wire logic                         instr_rvalid_i,
  input  wire prefetch_pkg::instr_t         instr_rdata_i,
  // Tagged response
  output logic                              resp_valid_o,
  output prefetch_pkg::fetch_entry_t        resp_entry_o
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;

  // Granted addresses waiting for their word
  prefetch_pkg::addr_t addr_q [depth];
  logic [ptr_w-1:0]    head_q, tail_q;
  logic                grant;

  ////////////////////
  // Request channel
  ////////////////////

  // Straight through, no buffering on the request side
  assign instr_req_o   = trans_valid_i;
  assign trans_ready_o = instr_gnt_i;
  assign instr_addr_o  = trans_req_i.addr;
  assign grant         = trans_valid_i && instr_gnt_i;

  ////////////////////
  // Address queue
  ////////////////////

  // Never more than depth in flight, the controller bounds it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_q <= '0;
      head_q <= '0;
    end else begin
      if (grant) begin
        tail_q <= (tail_q == ptr_w'(depth - 1)) ? '0 : tail_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        head_q <= (head_q == ptr_w'(depth - 1)) ? '0 : head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      addr_q[tail_q] <= trans_req_i.addr;
    end
  end

  ////////////////////
  // Response channel
  ////////////////////

  // Oldest address belongs to this word, responses are in order
  assign resp_valid_o = instr_rvalid_i;
  assign resp_entry_o = '{addr: addr_q[head_q], rdata: instr_rdata_i};

endmodule

`default_nettype wire

// File: src/prefetch_buffer.sv
// Prefetch buffer top: controller, fetch FIFO and bus adapter with the output bypass
`default_nettype none

module prefetch_buffer #(
  parameter int unsigned fifo_depth = 4,
  parameter int unsigned legacy_obi = 0
) (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  // Fetch stage
  input  wire logic                         req_i,
  input  wire logic                         branch_i,
  input  wire prefetch_pkg::addr_t          branch_addr_i,
  output logic                              busy_o,
  output logic                              fetch_valid_o,
  input  wire logic                         fetch_ready_i,
  output prefetch_pkg::fetch_entry_t        fetch_entry_o,
  // Instruction bus
  output logic                              instr_req_o,
  input  wire logic                         instr_gnt_i,
  output prefetch_pkg::addr_t               instr_addr_o,
  input  wire logic                         instr_rvalid_i,
  input  wire prefetch_pkg::instr_t         instr_rdata_i
);

  localparam int unsigned cnt_w = prefetch_pkg::cnt_width(fifo_depth);

  logic                       trans_valid;
  logic                       trans_ready;
  prefetch_pkg::bus_req_t     trans_req;
  logic                       resp_valid;
  prefetch_pkg::fetch_entry_t resp_entry;
  prefetch_pkg::fetch_entry_t fifo_rdata;
  logic                       fifo_push;
  logic                       fifo_pop;
  logic                       fifo_flush;
  logic [cnt_w-1:0]           fifo_cnt;
  logic                       fifo_empty;

  prefetch_controller #(
    .fifo_depth (fifo_depth),
    .legacy_obi (legacy_obi)
  ) controller_i (
    .clk, .rst_n,
    .req_i, .branch_i, .branch_addr_i, .busy_o,
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_req_o   (trans_req),
    .resp_valid_i  (resp_valid),
    .fetch_ready_i, .fetch_valid_o,
    .fifo_push_o   (fifo_push),
    .fifo_pop_o    (fifo_pop),
    .fifo_flush_o  (fifo_flush),
    .fifo_cnt_i    (fifo_cnt),
    .fifo_empty_i  (fifo_empty)
  );

  fetch_fifo #(
    .depth   (fifo_depth),
    .entry_t (prefetch_pkg::fetch_entry_t)
  ) fifo_i (
    .clk, .rst_n,
    .flush_i (fifo_flush),
    .push_i  (fifo_push),
    .wdata_i (resp_entry),
    .pop_i   (fifo_pop),
    .rdata_o (fifo_rdata),
    .cnt_o   (fifo_cnt),
    .empty_o (fifo_empty)
  );

  obi_instr_adapter #(
    .depth (fifo_depth)
  ) adapter_i (
    .clk, .rst_n,
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_req_i   (trans_req),
    .instr_req_o, .instr_gnt_i, .instr_addr_o, .instr_rvalid_i, .instr_rdata_i,
    .resp_valid_o  (resp_valid),
    .resp_entry_o  (resp_entry)
  );

  // Bypass, an empty FIFO hands over the arriving word
  assign fetch_entry_o = fifo_empty ? resp_entry : fifo_rdata;

endmodule

`default_nettype wire

// File: tests/instr_mem_model.sv
// Instruction memory model: random grant, in-order words returned 1 to 3 cycles after the grant
`default_nettype none

module instr_mem_model #(
  parameter logic [31:0] rdata_xor = 32'hA5A5_0000,
  parameter logic [31:0] seed_init = 32'h829f78b2
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 instr_req_i,
  output logic                      instr_gnt_o,
  input  wire prefetch_pkg::addr_t  instr_addr_i,
  output logic                      instr_rvalid_o,
  output prefetch_pkg::instr_t      instr_rdata_o,
  output int                        pending_o
);
  timeunit 1ns;
  timeprecision 100ps;

  integer                seed;
  int unsigned           cycle;
  prefetch_pkg::addr_t   addr_q [$];
  int unsigned           due_q [$];

  initial begin
    seed           = seed_init;
    cycle          = 0;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    pending_o      = 0;
  end

  ////////////////////
  // Drive side, 2 ns after the edge
  ////////////////////

  always @(posedge clk) begin
    cycle = cycle + 1;
    #2;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    // Oldest granted address answers first, once its latency is up
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      instr_rvalid_o = 1'b1;
      instr_rdata_o  = addr_q[0] ^ rdata_xor;
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end
    // Grant about half of the cycles
    instr_gnt_o = rst_n && (($random(seed) & 1) != 0);
  end

  ////////////////////
  // Handshake capture
  ////////////////////

  // Bus signals are settled mid-cycle and hold until the next edge
  always @(negedge clk) begin
    int unsigned due;
    if (instr_req_i && instr_gnt_o) begin
      due = cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
      // Keep responses in order, one per cycle
      if (due_q.size() > 0 && due <= due_q[$]) begin
        due = due_q[$] + 1;
      end
      addr_q.push_back(instr_addr_i);
      due_q.push_back(due);
    end
    // Granted requests still waiting for their word
    pending_o = addr_q.size();
  end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// Testbench clock and reset source: 20 ns clock, active-low reset held for the first cycles
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned reset_cycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running clock, 10 ns per half period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release reset just after an edge, like any other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #2 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/tb_prefetch_buffer.sv
// Prefetch buffer testbench with directed fetch, branch, alignment, back-pressure and idle tests
`default_nettype none

module tb_prefetch_buffer;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned fifo_depth = 4;
  localparam logic [31:0] rdata_xor  = 32'hA5A5_0000;
  localparam int unsigned max_cycles = 2000;

  logic clk, rst_n;
  logic req, branch, fetch_ready, busy, fetch_valid;
  logic instr_req, instr_gnt, instr_rvalid;
  prefetch_pkg::addr_t        branch_addr, instr_addr;
  prefetch_pkg::instr_t       instr_rdata;
  prefetch_pkg::fetch_entry_t fetch_entry;
  int                         pending;

  // Scoreboard with the next expected address and a window of banned addresses
  prefetch_pkg::addr_t exp_addr, stale_lo, stale_hi;
  logic                stale_seen;
  int unsigned         delivered, mismatches, cycles, max_pending;

  tb_clk_gen #(.reset_cycles(10)) clk_gen_i (.clk_o(clk), .rst_n_o(rst_n));

  instr_mem_model #(.rdata_xor(rdata_xor), .seed_init(32'h829f78b2)) mem_i (
    .clk, .rst_n,
    .instr_req_i(instr_req), .instr_gnt_o(instr_gnt), .instr_addr_i(instr_addr),
    .instr_rvalid_o(instr_rvalid), .instr_rdata_o(instr_rdata), .pending_o(pending)
  );

  prefetch_buffer #(.fifo_depth(fifo_depth), .legacy_obi(0)) dut_i (
    .clk, .rst_n,
    .req_i(req), .branch_i(branch), .branch_addr_i(branch_addr), .busy_o(busy),
    .fetch_valid_o(fetch_valid), .fetch_ready_i(fetch_ready), .fetch_entry_o(fetch_entry),
    .instr_req_o(instr_req), .instr_gnt_i(instr_gnt), .instr_addr_o(instr_addr),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata)
  );

  ////////////////////
  // Compare and helpers
  ////////////////////

  task automatic compare_entry(input prefetch_pkg::fetch_entry_t got,
                               input prefetch_pkg::fetch_entry_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %h/%h expected %h/%h", $time, what,
               got.addr, got.rdata, exp.addr, exp.rdata);
      mismatches++;
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH @%0t: %s got %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // Stimulus slot 2 ns after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic branch_to(input prefetch_pkg::addr_t target, input prefetch_pkg::addr_t first);
    branch      = 1'b1;
    branch_addr = target;
    exp_addr    = first;
    next_slot();
    branch      = 1'b0;
  endtask

  task automatic wait_entries(input int unsigned n);
    int unsigned target;
    target = delivered + n;
    do begin
      next_slot();
    end while (delivered < target);
  endtask

  // Every consumed word must be the next address of the stream
  always @(negedge clk) begin
    prefetch_pkg::fetch_entry_t exp;
    if (rst_n && fetch_valid && fetch_ready) begin
      exp.addr  = exp_addr;
      exp.rdata = exp_addr ^ rdata_xor;
      if (fetch_entry.addr >= stale_lo && fetch_entry.addr < stale_hi) begin
        stale_seen = 1'b1;
      end
      compare_entry(fetch_entry, exp, "delivered entry");
      exp_addr = exp_addr + 32'd4;
      delivered++;
    end
  end

  // Cycle budget and peak of granted but unanswered requests
  always @(posedge clk) begin
    cycles++;
    if (pending > max_pending) begin
      max_pending = pending;
    end
    if (cycles >= max_cycles) begin
      $display("Timeout: tests did not finish within %0d cycles, %0d mismatches",
               max_cycles, mismatches);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic idle_after_reset();
    @(negedge clk);
    compare_bit(busy, 1'b0, "busy after reset");
    compare_bit(fetch_valid, 1'b0, "fetch valid after reset");
    compare_bit(instr_req, 1'b0, "bus request after reset");
    next_slot();
  endtask

  task automatic sequential_fetch();
    req         = 1'b1;
    fetch_ready = 1'b1;
    branch_to(32'h100, 32'h100);
    wait_entries(20);
  endtask

  task automatic branch_in_flight();
    branch_to(32'h300, 32'h300);
    wait_entries(10);
    // Branch only with words on the way
    while (pending == 0) begin
      next_slot();
    end
    stale_lo   = 32'h300;
    stale_hi   = 32'h400;
    stale_seen = 1'b0;
    branch_to(32'h400, 32'h400);
    wait_entries(10);
    compare_bit(stale_seen, 1'b0, "old stream word after branch");
    stale_hi   = '0;
  endtask

  task automatic unaligned_branch();
    branch_to(32'h203, 32'h200);
    wait_entries(8);
  endtask

  task automatic stall_consumer();
    fetch_ready = 1'b0;
    max_pending = 0;
    repeat (30) next_slot();
    @(negedge clk);
    // Full FIFO and nothing in flight leaves no room for another request
    compare_bit(instr_req, 1'b0, "bus request with FIFO full");
    compare_bit(fetch_valid, 1'b1, "words held while stalled");
    compare_bit(max_pending <= fifo_depth, 1'b1, "outstanding within FIFO depth");
    next_slot();
    fetch_ready = 1'b1;
    wait_entries(12);
  endtask

  task automatic drain_to_idle();
    req = 1'b0;
    next_slot();
    // Granted words still on the bus keep the buffer busy
    while (pending != 0) begin
      @(negedge clk);
      compare_bit(busy, 1'b1, "busy with requests outstanding");
      next_slot();
    end
    repeat (10) begin
      @(negedge clk);
      compare_bit(busy, 1'b0, "busy when idle");
      compare_bit(instr_req, 1'b0, "bus request when idle");
      next_slot();
    end
  endtask

  initial begin
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b0;
    exp_addr    = '0;
    stale_lo    = '0;
    stale_hi    = '0;
    stale_seen  = 1'b0;
    delivered   = 0;
    mismatches  = 0;
    cycles      = 0;
    max_pending = 0;
    @(posedge rst_n);
    next_slot();
    idle_after_reset();
    sequential_fetch();
    branch_in_flight();
    unaligned_branch();
    stall_consumer();
    drain_to_idle();
    $display("Summary: %0d mismatches, %0d entries checked", mismatches, delivered);
    if (mismatches == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
